// File: Makefile
TOP := eth_loop_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

obj_dir/V$(TOP): verilog.f hw/*.sv hw/*.svh dv/*.sv
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -qF '*** FAILED ***' sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '*** PASSED ***' sim.log; then echo "Simulation gave no verdict"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: dv/eth_loop_assertions.sv
// Loopback core assertions
module eth_loop_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic       tx_en,
    input logic       rd_en,
    input logic       rd_last,
    input logic       frame_avail,
    input logic [7:0] ifg
);

    timeunit 1ns;
    timeprecision 100ps;

    // Idle cycles since tx_en last fell, held at the top
    logic [7:0] idle_cnt;
    // High between the first and the last read of a frame
    logic       in_frame;
    // Sticky failure flags, watched by the testbench
    bit         gap_failed = 1'b0;
    bit         read_failed = 1'b0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idle_cnt <= '1;
        end else if (tx_en) begin
            idle_cnt <= '0;
        end else if (idle_cnt != '1) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_frame <= 1'b0;
        end else if (rd_en) begin
            in_frame <= !rd_last;
        end
    end

    tx_gap_held: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tx_en) |-> (idle_cnt >= ifg))
        else begin
            gap_failed = 1'b1;
            $error("tx_en rose %0d cycles after its last fall with ifg %0d", idle_cnt, ifg);
        end

    // A read run may only continue until the head frame's last flag
    read_needs_frame: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> (frame_avail || in_frame))
        else begin
            read_failed = 1'b1;
            $error("rd_en with no committed frame and no frame in progress");
        end

endmodule

// File: dv/eth_loop_tb.sv
// Loopback core testbench
`include "eth_loop_cfg.svh"

module eth_loop_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import eth_frame_pkg::*;
    import loop_reg_pkg::*;

    // Frame classes of the reference model
    localparam int IGNORED    = 0;
    localparam int BAD        = 1;
    localparam int DROPPED    = 2;
    localparam int GOOD       = 3;
    localparam int FIFO_BYTES = 2 ** `FIFO_ADDR_W;
    localparam int N_FRAMES   = 32;
    // Longest frame, input gap, widest ifg and drain time, four cycles each
    localparam int WATCHDOG_CYCLES = N_FRAMES * (`MAX_FRAME_LEN + 12 + 52 + 64) * 4;

    logic              clk;
    logic              rst_n;
    logic [7:0]        rxd;
    logic              rx_dv;
    logic              rx_er;
    logic [7:0]        txd;
    logic              tx_en;
    logic              cfg_wr;
    reg_addr_e         cfg_addr;
    logic [`CNT_W-1:0] cfg_wdata;
    logic [`CNT_W-1:0] cfg_rdata;

    // Expected and captured frames
    logic [7:0] exp_bytes [$];
    int         exp_lens [$];
    logic [7:0] act_bytes [$];
    int         act_lens [$];
    int         exp_good;
    int         exp_bad;
    int         exp_drop;
    int         fifo_used;
    int         ifg_now;
    int         tx_frames;
    bit         rx_on;
    string      test_name;

    eth_loop_top eth_loop_top_inst (.*);

    bind eth_loop_top eth_loop_assertions eth_loop_assertions_inst (
        .clk(clk), .rst_n(rst_n), .tx_en(tx_en), .rd_en(rd_en), .rd_last(rd_last),
        .frame_avail(frame_avail), .ifg(ifg)
    );

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            stop_run();
        end
    endtask

    // Outcome of one received frame
    function automatic int classify_frame(input int len, input bit has_err,
                                          input bit rx_open, input int used);
        if (!rx_open)
            return IGNORED;
        if (has_err || len < `MIN_FRAME_LEN || len > `MAX_FRAME_LEN)
            return BAD;
        if (used + len > FIFO_BYTES)
            return DROPPED;
        return GOOD;
    endfunction

    task automatic write_reg(input reg_addr_e addr, input int data);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= `CNT_W'(data);
        @(posedge clk);
        cfg_wr <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_e addr, output int data);
        @(posedge clk);
        cfg_addr <= addr;
        @(posedge clk);
        data = int'(cfg_rdata);
    endtask

    // Drives one frame, err_pos below zero means no rx_er
    task automatic send_frame(input int len, input int err_pos);
        logic [7:0] data [$];
        int         cls;
        for (int i = 0; i < len; i++) begin
            data.push_back(8'($urandom));
            @(posedge clk);
            rx_dv <= 1'b1;
            rxd   <= data[i];
            rx_er <= (i == err_pos);
        end
        @(posedge clk);
        rx_dv <= 1'b0;
        rx_er <= 1'b0;
        rxd   <= 8'h00;
        cls = classify_frame(len, err_pos >= 0, rx_on, fifo_used);
        case (cls)
            BAD:     exp_bad++;
            DROPPED: exp_drop++;
            GOOD: begin
                exp_good++;
                fifo_used += len;
                exp_lens.push_back(len);
                foreach (data[i]) exp_bytes.push_back(data[i]);
            end
            default: ;
        endcase
        repeat (ifg_now + 4) @(posedge clk);
    endtask

    task automatic wait_drain();
        while (exp_lens.size() != 0 || eth_loop_top_inst.gmii_tx_frame_inst.state != TX_IDLE)
            @(posedge clk);
        repeat (64) @(posedge clk);
    endtask

    task automatic check_counters();
        int value;
        read_reg(REG_GOOD, value);
        check_value({test_name, " REG_GOOD"}, exp_good, value);
        read_reg(REG_BAD, value);
        check_value({test_name, " REG_BAD"}, exp_bad, value);
        read_reg(REG_DROP, value);
        check_value({test_name, " REG_DROP"}, exp_drop, value);
    endtask

    // Captures tx_en frames and measures the idle gap before each one
    initial begin : tx_monitor
        int len;
        int idle;
        bit framed;
        len    = 0;
        idle   = 0;
        framed = 0;
        forever begin
            @(posedge clk);
            if (tx_en === 1'b1) begin
                if (len == 0 && framed && idle < ifg_now) begin
                    $display("Gap of %0d idle cycles is shorter than ifg %0d", idle, ifg_now);
                    stop_run();
                end
                act_bytes.push_back(txd);
                len++;
                idle = 0;
            end else begin
                if (len != 0) begin
                    act_lens.push_back(len);
                    tx_frames++;
                    framed = 1;
                end
                len = 0;
                idle++;
            end
        end
    end

    initial begin : compare
        int len;
        forever begin
            while (act_lens.size() == 0)
                @(posedge clk);
            len = act_lens.pop_front();
            if (exp_lens.size() == 0) begin
                $display("A frame of %0d bytes was sent while none was expected", len);
                stop_run();
            end
            check_value({test_name, " length"}, exp_lens.pop_front(), len);
            for (int i = 0; i < len; i++)
                check_value({test_name, " byte"}, exp_bytes.pop_front(), act_bytes.pop_front());
            fifo_used -= len;
        end
    end

    // Flags raised by the bound checker
    initial begin : assertion_watch
        forever begin
            @(posedge clk);
            if (eth_loop_top_inst.eth_loop_assertions_inst.gap_failed
                    || eth_loop_top_inst.eth_loop_assertions_inst.read_failed) begin
                $display("A bound assertion on the loopback core failed");
                stop_run();
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        stop_run();
    end

    initial begin : stimulus
        int value;
        int legal;
        int seen;
        void'($urandom(15));
        clk       = 1'b0;
        rst_n     = 1'b0;
        rxd       = 8'h00;
        rx_dv     = 1'b0;
        rx_er     = 1'b0;
        cfg_wr    = 1'b0;
        cfg_addr  = REG_CTRL;
        cfg_wdata = '0;
        exp_good  = 0;
        exp_bad   = 0;
        exp_drop  = 0;
        fifo_used = 0;
        tx_frames = 0;
        ifg_now   = `DEFAULT_IFG;
        rx_on     = 1'b1;
        test_name = "reset_values";
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        read_reg(REG_CTRL, value);
        check_value({test_name, " REG_CTRL"}, 3, value);
        read_reg(REG_IFG, value);
        check_value({test_name, " REG_IFG"}, `DEFAULT_IFG, value);
        check_counters();

        test_name = "good_loopback";
        for (int i = 0; i < 8; i++)
            send_frame($urandom_range(`MAX_FRAME_LEN, `MIN_FRAME_LEN), -1);
        wait_drain();
        check_counters();

        test_name = "bad_frames";
        for (int i = 0; i < 2; i++) begin
            value = $urandom_range(`MAX_FRAME_LEN, `MIN_FRAME_LEN);
            send_frame(value, $urandom_range(value - 1, 0));
            send_frame($urandom_range(`MIN_FRAME_LEN - 1, 1), -1);
            send_frame($urandom_range(`MAX_FRAME_LEN + 12, `MAX_FRAME_LEN + 1), -1);
        end
        wait_drain();
        check_counters();

        test_name = "ifg_program";
        ifg_now = $urandom_range(48, 16);
        write_reg(REG_IFG, ifg_now);
        read_reg(REG_IFG, value);
        check_value({test_name, " REG_IFG"}, ifg_now, value);
        for (int i = 0; i < 6; i++)
            send_frame($urandom_range(`MAX_FRAME_LEN, `MIN_FRAME_LEN), -1);
        wait_drain();
        check_counters();

        test_name = "rx_disabled";
        rx_on = 1'b0;
        write_reg(REG_CTRL, 2);
        seen = tx_frames;
        for (int i = 0; i < 3; i++)
            send_frame($urandom_range(`MAX_FRAME_LEN, `MIN_FRAME_LEN), -1);
        repeat (64) @(posedge clk);
        check_value({test_name, " frames sent"}, seen, tx_frames);
        check_counters();
        rx_on = 1'b1;

        test_name = "tx_disabled";
        write_reg(REG_CTRL, 1);
        for (int i = 0; i < 3; i++)
            send_frame($urandom_range(64, `MIN_FRAME_LEN), -1);
        repeat (64) @(posedge clk);
        check_value({test_name, " frames sent"}, seen, tx_frames);
        write_reg(REG_CTRL, 3);
        wait_drain();
        check_counters();

        // Burst larger than the FIFO while transmit is held
        test_name = "fifo_overflow";
        legal = exp_good + exp_drop;
        write_reg(REG_CTRL, 1);
        seen = tx_frames;
        for (int i = 0; i < 6; i++)
            send_frame($urandom_range(`MAX_FRAME_LEN, 60), -1);
        check_value({test_name, " frames sent"}, seen, tx_frames);
        write_reg(REG_CTRL, 3);
        wait_drain();
        read_reg(REG_GOOD, value);
        read_reg(REG_DROP, seen);
        check_value({test_name, " good plus drop"}, legal + 6, value + seen);
        check_counters();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: hw/eth_frame_pkg.sv
// Frame path types
package eth_frame_pkg;

    // Receive framer states
    typedef enum logic [1:0] {
        RX_IDLE    = 2'd0,
        // Forwarding bytes into the FIFO
        RX_FRAME   = 2'd1,
        // Frame began while receive was disabled
        RX_DISCARD = 2'd2
    } rx_state_e;

    // Transmit framer states
    typedef enum logic [1:0] {
        TX_IDLE = 2'd0,
        TX_SEND = 2'd1,
        // Holding the inter-frame gap
        TX_GAP  = 2'd2
    } tx_state_e;

endpackage

// File: hw/eth_loop_cfg.svh
// Loopback core configuration
`ifndef ETH_LOOP_CFG_SVH
`define ETH_LOOP_CFG_SVH

// FIFO depth is 2**FIFO_ADDR_W bytes
`define FIFO_ADDR_W 8

// Accepted frame length range in bytes, scaled down for simulation
`define MIN_FRAME_LEN 16
`define MAX_FRAME_LEN 128

// Inter-frame gap after reset, in cycles
`define DEFAULT_IFG 12

// Statistics counter and register data width
`define CNT_W 16

`endif

// File: hw/eth_loop_top.sv
// Ethernet frame loopback core
`include "eth_loop_cfg.svh"

module eth_loop_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              rxd,
    input  logic                    rx_dv,
    input  logic                    rx_er,
    output logic [7:0]              txd,
    output logic                    tx_en,
    input  logic                    cfg_wr,
    input  loop_reg_pkg::reg_addr_e cfg_addr,
    input  logic [`CNT_W-1:0]       cfg_wdata,
    output logic [`CNT_W-1:0]       cfg_rdata
);

    // Control levels and statistics pulses
    logic       rx_enable;
    logic       tx_enable;
    logic [7:0] ifg;
    logic       stat_good;
    logic       stat_bad;
    logic       stat_drop;

    // Receive side into the FIFO
    logic       wr_en;
    logic [7:0] wr_data;
    logic       frame_end;
    logic       frame_good;

    // FIFO out to the transmit side
    logic       frame_avail;
    logic       rd_en;
    logic [7:0] rd_data;
    logic       rd_last;

    loop_cfg_regs loop_cfg_regs_inst (.*);

    gmii_rx_frame gmii_rx_frame_inst (.*);

    frame_fifo frame_fifo_inst (.*);

    gmii_tx_frame gmii_tx_frame_inst (.*);

endmodule

// File: hw/frame_fifo.sv
// Frame FIFO with per-frame commit
`include "eth_loop_cfg.svh"

module frame_fifo (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       frame_end,
    input  logic       frame_good,
    output logic       frame_avail,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       rd_last,
    output logic       stat_good,
    output logic       stat_drop
);

    // Entry is {last flag, data byte}
    logic [8:0]            mem [2**`FIFO_ADDR_W];
    logic [`FIFO_ADDR_W:0] wr_ptr;
    logic [`FIFO_ADDR_W:0] commit_ptr;
    logic [`FIFO_ADDR_W:0] rd_ptr;
    logic [`FIFO_ADDR_W:0] frame_cnt;
    // Byte held back until we know whether it ends the frame
    logic [7:0]            pend_data;
    logic                  pend_valid;
    logic                  overflow;
    logic                  full;
    logic                  mem_wr;
    logic                  commit;
    logic                  frame_read;

    assign full = (wr_ptr[`FIFO_ADDR_W] != rd_ptr[`FIFO_ADDR_W])
               && (wr_ptr[`FIFO_ADDR_W-1:0] == rd_ptr[`FIFO_ADDR_W-1:0]);
    assign mem_wr      = pend_valid && (wr_en || frame_end) && !overflow && !full;
    assign commit      = frame_end && frame_good && mem_wr;
    assign frame_read  = rd_en && rd_last;
    assign frame_avail = (frame_cnt != '0);
    assign rd_data     = mem[rd_ptr[`FIFO_ADDR_W-1:0]][7:0];
    assign rd_last     = mem[rd_ptr[`FIFO_ADDR_W-1:0]][8];

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr[`FIFO_ADDR_W-1:0]] <= {frame_end, pend_data};
        end
        if (wr_en) begin
            pend_data <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            frame_cnt  <= '0;
            pend_valid <= 1'b0;
            overflow   <= 1'b0;
            stat_good  <= 1'b0;
            stat_drop  <= 1'b0;
        end else begin
            stat_good <= commit;
            stat_drop <= frame_end && frame_good && !commit;
            if (frame_end) begin
                // Keep the frame or rewind to the last committed one
                pend_valid <= 1'b0;
                overflow   <= 1'b0;
                if (commit) begin
                    wr_ptr     <= wr_ptr + 1'b1;
                    commit_ptr <= wr_ptr + 1'b1;
                end else begin
                    wr_ptr <= commit_ptr;
                end
            end else begin
                if (wr_en) begin
                    pend_valid <= 1'b1;
                end
                if (wr_en && pend_valid && full) begin
                    overflow <= 1'b1;
                end
                if (mem_wr) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({commit, frame_read})
                2'b10:   frame_cnt <= frame_cnt + 1'b1;
                2'b01:   frame_cnt <= frame_cnt - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: hw/gmii_rx_frame.sv
// GMII receive framer
`include "eth_loop_cfg.svh"

module gmii_rx_frame (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] rxd,
    input  logic       rx_dv,
    input  logic       rx_er,
    input  logic       rx_enable,
    output logic       wr_en,
    output logic [7:0] wr_data,
    output logic       frame_end,
    output logic       frame_good,
    output logic       stat_bad
);

    import eth_frame_pkg::*;

    // Wide enough to count past the maximum length
    localparam int LEN_W = $clog2(`MAX_FRAME_LEN + 2);

    rx_state_e        state;
    logic [LEN_W-1:0] frame_len;
    logic             frame_err;
    logic             len_ok;

    assign len_ok = (frame_len >= LEN_W'(`MIN_FRAME_LEN))
                 && (frame_len <= LEN_W'(`MAX_FRAME_LEN));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            wr_en     <= 1'b0;
            frame_end <= 1'b0;
            stat_bad  <= 1'b0;
            frame_len <= '0;
            frame_err <= 1'b0;
        end else begin
            wr_en     <= 1'b0;
            frame_end <= 1'b0;
            stat_bad  <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // Accept or ignore the whole frame at its first byte
                    if (rx_dv && rx_enable) begin
                        state     <= RX_FRAME;
                        wr_en     <= 1'b1;
                        frame_len <= LEN_W'(1);
                        frame_err <= rx_er;
                    end else if (rx_dv) begin
                        state <= RX_DISCARD;
                    end
                end
                RX_FRAME: begin
                    if (rx_dv) begin
                        wr_en     <= 1'b1;
                        frame_err <= frame_err | rx_er;
                        if (frame_len != '1) begin
                            frame_len <= frame_len + 1'b1;
                        end
                    end else begin
                        state     <= RX_IDLE;
                        frame_end <= 1'b1;
                        stat_bad  <= frame_err || !len_ok;
                    end
                end
                RX_DISCARD: begin
                    if (!rx_dv) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Verdict settles once the frame's last byte is counted
    always_ff @(posedge clk) begin
        wr_data    <= rxd;
        frame_good <= !frame_err && len_ok;
    end

endmodule

// File: hw/gmii_tx_frame.sv
// GMII transmit framer
module gmii_tx_frame (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       frame_avail,
    input  logic [7:0] rd_data,
    input  logic       rd_last,
    output logic       rd_en,
    input  logic       tx_enable,
    input  logic [7:0] ifg,
    output logic [7:0] txd,
    output logic       tx_en
);

    import eth_frame_pkg::*;

    tx_state_e  state;
    logic [7:0] gap_cnt;

    // Head byte is read ahead, so the first one leaves on the start cycle
    assign rd_en = (state == TX_SEND) || ((state == TX_IDLE) && frame_avail && tx_enable);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            gap_cnt <= '0;
            tx_en   <= 1'b0;
        end else begin
            tx_en <= rd_en;
            case (state)
                TX_IDLE: begin
                    if (rd_en) begin
                        state   <= rd_last ? TX_GAP : TX_SEND;
                        gap_cnt <= 8'd1;
                    end
                end
                TX_SEND: begin
                    if (rd_last) begin
                        state   <= TX_GAP;
                        gap_cnt <= 8'd1;
                    end
                end
                TX_GAP: begin
                    // First gap cycle still carries the last byte
                    if (gap_cnt >= ifg) begin
                        state <= TX_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        txd <= rd_en ? rd_data : 8'h00;
    end

endmodule

// File: hw/loop_cfg_regs.sv
// Control and statistics registers
`include "eth_loop_cfg.svh"

module loop_cfg_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_wr,
    input  loop_reg_pkg::reg_addr_e cfg_addr,
    input  logic [`CNT_W-1:0]       cfg_wdata,
    output logic [`CNT_W-1:0]       cfg_rdata,
    input  logic                    stat_good,
    input  logic                    stat_bad,
    input  logic                    stat_drop,
    output logic                    rx_enable,
    output logic                    tx_enable,
    output logic [7:0]              ifg
);

    import loop_reg_pkg::*;

    // Good, bad and drop, in that order
    logic [2:0]        stat_pulse;
    logic [`CNT_W-1:0] stat_cnt [3];

    assign stat_pulse = {stat_drop, stat_bad, stat_good};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_enable <= 1'b1;
            tx_enable <= 1'b1;
            ifg       <= 8'(`DEFAULT_IFG);
        end else if (cfg_wr) begin
            case (cfg_addr)
                REG_CTRL: begin
                    rx_enable <= cfg_wdata[0];
                    tx_enable <= cfg_wdata[1];
                end
                REG_IFG: ifg <= cfg_wdata[7:0];
                default: ;
            endcase
        end
    end

    // Counters stick at all ones
    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (!rst_n) begin
                stat_cnt[i] <= '0;
            end else if (stat_pulse[i] && (stat_cnt[i] != '1)) begin
                stat_cnt[i] <= stat_cnt[i] + 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            REG_CTRL: cfg_rdata = `CNT_W'({tx_enable, rx_enable});
            REG_IFG:  cfg_rdata = `CNT_W'(ifg);
            REG_GOOD: cfg_rdata = stat_cnt[0];
            REG_BAD:  cfg_rdata = stat_cnt[1];
            REG_DROP: cfg_rdata = stat_cnt[2];
            default:  cfg_rdata = '0;
        endcase
    end

endmodule

// File: hw/loop_reg_pkg.sv
// Register map types
package loop_reg_pkg;

    // Register addresses
    typedef enum logic [2:0] {
        // rx_enable in bit 0, tx_enable in bit 1
        REG_CTRL = 3'd0,
        // Inter-frame gap in cycles
        REG_IFG  = 3'd1,
        // Read-only frame statistics
        REG_GOOD = 3'd2,
        REG_BAD  = 3'd3,
        REG_DROP = 3'd4
    } reg_addr_e;

endpackage

// File: verilog.f
+incdir+hw
hw/eth_frame_pkg.sv
hw/loop_reg_pkg.sv
hw/loop_cfg_regs.sv
hw/gmii_rx_frame.sv
hw/frame_fifo.sv
hw/gmii_tx_frame.sv
hw/eth_loop_top.sv
dv/eth_loop_assertions.sv
dv/eth_loop_tb.sv
